//--- hdl/lane_fabric_macros.svh
`ifndef LANE_FABRIC_MACROS_SVH
`define LANE_FABRIC_MACROS_SVH

// --------------------
// fabric dimensions
// --------------------

// number of lane FIFOs
`define LANE_COUNT 4

`define LANE_DEPTH 8        // words per lane FIFO
`define LANE_DATA_WIDTH 16  // payload bits per word

`endif

//--- hdl/lane_fabric_pkg.sv
`include "lane_fabric_macros.svh"

package lane_fabric_pkg;

    // --------------------
    // lane addressing
    // --------------------

    // index of one lane, wide enough for every lane
    typedef logic [$clog2(`LANE_COUNT)-1:0] lane_id_t;

    // one bit per lane; write enables, read enables, full and empty flags
    typedef logic [`LANE_COUNT-1:0] lane_mask_t;

    // --------------------
    // stream word
    // --------------------

    // tag in the upper bits, payload below
    typedef struct packed
    {
        lane_id_t                    lane;  // destination lane on input, source lane on output
        logic [`LANE_DATA_WIDTH-1:0] data;
    } lane_word_t;

endpackage

//--- hdl/lane_fifo.sv
module lane_fifo #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 16
)
(
    input  logic             reset,
    input  logic             wr_clk,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_clk,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int ADDR_WIDTH = $clog2(DEPTH);
    localparam int PTR_WIDTH  = ADDR_WIDTH + 1;  // extra bit tells full from empty

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr, wr_ptr_next;
    logic [PTR_WIDTH-1:0] rd_ptr, rd_ptr_next;
    logic                 full_now, empty_now;
    logic                 do_write, do_read;

    // unknown bits read back as zero
    function automatic logic [WIDTH-1:0] clean_bits(input logic [WIDTH-1:0] value);
        logic [WIDTH-1:0] result;
        for (int i = 0; i < WIDTH; i++)
        begin
            result[i] = (value[i] === 1'b1);
        end
        return result;
    endfunction

    // --------------------
    // write side
    // --------------------
    always_ff @(posedge wr_clk)
    begin
        if (do_write)
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= din;
    end

    always_ff @(posedge wr_clk, posedge reset)
    begin
        if (reset)
            wr_ptr <= '0;
        else
            wr_ptr <= wr_ptr_next;
    end

    // --------------------
    // read side
    // --------------------
    always_ff @(posedge rd_clk)
    begin
        if (do_read)
            dout <= clean_bits(mem[rd_ptr[ADDR_WIDTH-1:0]]);  // word popped by this read
    end

    always_ff @(posedge rd_clk, posedge reset)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            empty  <= 1'b1;
        end
        else
        begin
            rd_ptr <= rd_ptr_next;
            empty  <= (wr_ptr == rd_ptr_next);  // lags a write by one edge
        end
    end

    assign do_write    = wr_en && !full_now;
    assign do_read     = rd_en && !empty_now;
    assign wr_ptr_next = do_write ? wr_ptr + 1'b1 : wr_ptr;
    assign rd_ptr_next = do_read ? rd_ptr + 1'b1 : rd_ptr;

    assign empty_now = (wr_ptr == rd_ptr);
    // same slot, one lap apart
    assign full_now  = (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]) &&
                       (wr_ptr[PTR_WIDTH-1] != rd_ptr[PTR_WIDTH-1]);
    assign full      = full_now;

endmodule

//--- hdl/lane_dispatch.sv
`include "lane_fabric_macros.svh"

module lane_dispatch
(
    input  logic                         in_valid,
    input  lane_fabric_pkg::lane_word_t  in_word,
    input  lane_fabric_pkg::lane_mask_t  full_mask,
    output lane_fabric_pkg::lane_mask_t  wr_en_mask,
    output logic [`LANE_DATA_WIDTH-1:0]  din,
    output logic                         drop
);

    lane_fabric_pkg::lane_mask_t target;   // one-hot lane named by the tag
    lane_fabric_pkg::lane_mask_t blocked;  // target bit where that lane is full

    // --------------------
    // tag decode
    // --------------------
    always_comb
    begin
        target = '0;
        target[in_word.lane] = 1'b1;
    end

    assign blocked = target & full_mask;

    // --------------------
    // steering
    // --------------------

    // only the tagged lane is written, and only when it has room
    always_comb
    begin
        if (in_valid)
            wr_en_mask = target & ~full_mask;
        else
            wr_en_mask = '0;
    end

    assign drop = in_valid && (|blocked);  // word lost, lane full

    // payload goes to every lane, the enable picks one
    assign din = in_word.data;

endmodule

//--- hdl/lane_drain.sv
`include "lane_fabric_macros.svh"

module lane_drain
(
    input  logic                         rd_clk,
    input  logic                         reset,
    input  logic                         hold,
    input  lane_fabric_pkg::lane_mask_t  empty_mask,
    input  logic [`LANE_DATA_WIDTH-1:0]  lane_dout [`LANE_COUNT],
    output lane_fabric_pkg::lane_mask_t  rd_en_mask,
    output logic                         out_valid,
    output lane_fabric_pkg::lane_word_t  out_word
);

    lane_fabric_pkg::lane_id_t rr_ptr;     // lane with first claim this cycle
    lane_fabric_pkg::lane_id_t pick;
    lane_fabric_pkg::lane_id_t lane_q;     // lane read at the last edge
    logic                      found;
    logic                      read_now;
    logic                      valid_q;

    // --------------------
    // round-robin select
    // --------------------
    always_comb
    begin : p_pick
        lane_fabric_pkg::lane_id_t idx;
        found = 1'b0;
        pick  = rr_ptr;
        for (int off = 0; off < `LANE_COUNT; off++)
        begin
            idx = lane_fabric_pkg::lane_id_t'((int'(rr_ptr) + off) % `LANE_COUNT);
            if (!found && !empty_mask[idx])
            begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    assign read_now = found && !hold;  // hold blocks every read

    always_comb
    begin
        rd_en_mask = '0;
        if (read_now)
            rd_en_mask[pick] = 1'b1;
    end

    // --------------------
    // output register
    // --------------------
    always_ff @(posedge rd_clk, posedge reset)
    begin
        if (reset)
        begin
            rr_ptr  <= '0;
            lane_q  <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= read_now;
            if (read_now)
            begin
                lane_q <= pick;
                // next turn starts after the lane just served
                rr_ptr <= lane_fabric_pkg::lane_id_t'((int'(pick) + 1) % `LANE_COUNT);
            end
        end
    end

    assign out_valid     = valid_q;
    assign out_word.lane = lane_q;
    assign out_word.data = lane_dout[lane_q];  // fifo dout holds the popped word

endmodule

//--- hdl/lane_fabric.sv
`include "lane_fabric_macros.svh"

module lane_fabric
(
    input  logic                         rd_clk,
    input  logic                         reset,
    input  logic                         in_valid,
    input  lane_fabric_pkg::lane_word_t  in_word,
    input  logic                         hold,
    output logic                         drop,
    output logic                         out_valid,
    output lane_fabric_pkg::lane_word_t  out_word
);

    lane_fabric_pkg::lane_mask_t  wr_en_mask;
    lane_fabric_pkg::lane_mask_t  full_mask;
    lane_fabric_pkg::lane_mask_t  rd_en_mask;
    lane_fabric_pkg::lane_mask_t  empty_mask;
    logic [`LANE_DATA_WIDTH-1:0]  lane_din;
    logic [`LANE_DATA_WIDTH-1:0]  lane_dout [`LANE_COUNT];

    // --------------------
    // input steering
    // --------------------
    lane_dispatch u_dispatch
    (
        .in_valid   (in_valid),
        .in_word    (in_word),
        .full_mask  (full_mask),
        .wr_en_mask (wr_en_mask),
        .din        (lane_din),
        .drop       (drop)
    );

    // --------------------
    // lane buffers
    // --------------------

    // both sides clocked from rd_clk
    for (genvar i = 0; i < `LANE_COUNT; i++)
    begin : g_lane
        lane_fifo #(
            .DEPTH (`LANE_DEPTH),
            .WIDTH (`LANE_DATA_WIDTH)
        ) u_fifo
        (
            .reset  (reset),
            .wr_clk (rd_clk),
            .wr_en  (wr_en_mask[i]),
            .din    (lane_din),
            .full   (full_mask[i]),
            .rd_clk (rd_clk),
            .rd_en  (rd_en_mask[i]),
            .dout   (lane_dout[i]),
            .empty  (empty_mask[i])
        );
    end

    lane_drain u_drain
    (
        .rd_clk     (rd_clk),
        .reset      (reset),
        .hold       (hold),
        .empty_mask (empty_mask),
        .lane_dout  (lane_dout),
        .rd_en_mask (rd_en_mask),
        .out_valid  (out_valid),
        .out_word   (out_word)
    );

endmodule

//--- tb/lane_fabric_clkgen.sv
module lane_fabric_clkgen #(
    parameter int PERIOD = 40
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD / 2);
            clk = ~clk;  // free running
        end
    end

endmodule

//--- tb/lane_fabric_tb.sv
`include "lane_fabric_macros.svh"

module lane_fabric_tb;

    typedef struct packed
    {
        lane_fabric_pkg::lane_id_t   lane;
        logic [`LANE_DATA_WIDTH-1:0] data;
        logic                        hold;
    } stim_row_t;

    localparam int OVER_ROWS  = `LANE_DEPTH + 2;  // two more than one lane holds
    localparam int ROT_ROWS   = 3 * `LANE_COUNT;
    localparam int RAND_ROWS  = 64;
    localparam int TABLE_ROWS = OVER_ROWS + ROT_ROWS + RAND_ROWS;
    localparam int DRAIN_MAX  = 200;

    logic                        rd_clk;
    logic                        reset;
    logic                        in_valid;
    lane_fabric_pkg::lane_word_t in_word;
    logic                        hold;
    logic                        drop;
    logic                        out_valid;
    lane_fabric_pkg::lane_word_t out_word;

    stim_row_t                   stim_table [TABLE_ROWS];
    integer                      seed;
    int                          drop_count;
    int                          out_count;

    // --------------------
    // reference model
    // --------------------
    logic [`LANE_DATA_WIDTH-1:0] model_q [`LANE_COUNT][$];
    int                          occ [`LANE_COUNT];         // words held per lane
    logic                        wrote_last [`LANE_COUNT];  // write taken at the last edge
    lane_fabric_pkg::lane_id_t   rr_model;
    logic                        pend_valid;                // read due at the next edge
    lane_fabric_pkg::lane_word_t pend_word;

    lane_fabric_clkgen #(.PERIOD(40)) u_clkgen (.clk(rd_clk));

    lane_fabric u_dut
    (
        .rd_clk    (rd_clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .hold      (hold),
        .drop      (drop),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input lane_fabric_pkg::lane_word_t expected,
                              input lane_fabric_pkg::lane_word_t actual);
        if (actual !== expected)
            abort_run($sformatf("FAILED %s expected 0x%h got 0x%h", name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abort_run($sformatf("FAILED %s expected 0x%h got 0x%h", name, expected, actual));
    endtask

    // round robin from the pointer; empty flags trail a write by one edge
    task automatic predict_read(input logic hold_level);
        lane_fabric_pkg::lane_id_t idx;
        pend_valid = 1'b0;
        for (int off = 0; off < `LANE_COUNT; off++)
        begin
            idx = lane_fabric_pkg::lane_id_t'((int'(rr_model) + off) % `LANE_COUNT);
            if (!hold_level && !pend_valid && (occ[idx] - int'(wrote_last[idx])) > 0)
            begin
                pend_valid     = 1'b1;
                pend_word.lane = idx;
                pend_word.data = model_q[idx].pop_front();
                rr_model = lane_fabric_pkg::lane_id_t'((int'(idx) + 1) % `LANE_COUNT);
            end
        end
    endtask

    // check the outputs of the last edge and drive the next inputs
    task automatic run_cycle(input logic valid, input lane_fabric_pkg::lane_id_t lane,
                             input logic [`LANE_DATA_WIDTH-1:0] data, input logic hold_level);
        logic exp_drop;
        @(negedge rd_clk);
        check_bit("out_valid", pend_valid, out_valid);
        if (out_valid === 1'b1)
            out_count++;
        if (pend_valid)
        begin
            check_word("out_word", pend_word, out_word);
            occ[pend_word.lane] = occ[pend_word.lane] - 1;
        end
        predict_read(hold_level);
        for (int i = 0; i < `LANE_COUNT; i++)
            wrote_last[i] = 1'b0;
        in_valid     = valid;
        in_word.lane = lane;
        in_word.data = data;
        hold         = hold_level;
        exp_drop     = valid && (occ[lane] == `LANE_DEPTH);
        #1;
        check_bit("drop", exp_drop, drop);  // combinational in the cycle of the strobe
        if (drop === 1'b1)
            drop_count++;
        if (valid && !exp_drop)
        begin
            model_q[lane].push_back(data);
            occ[lane]        = occ[lane] + 1;
            wrote_last[lane] = 1'b1;
        end
    endtask

    task automatic apply_rows(input int first, input int last);
        for (int r = first; r <= last; r++)
            run_cycle(1'b1, stim_table[r].lane, stim_table[r].data, stim_table[r].hold);
    endtask

    task automatic drain_all();
        int waited;
        int left;
        waited = 0;
        left   = 1;
        while (left != 0)
        begin
            run_cycle(1'b0, '0, '0, 1'b0);
            left = int'(pend_valid);
            for (int i = 0; i < `LANE_COUNT; i++)
                left = left + occ[i];
            waited++;
            if (waited > DRAIN_MAX)
                abort_run("timeout while waiting for the lane buffers to drain");
        end
    endtask

    task automatic build_table();
        logic [31:0] r;
        for (int i = 0; i < TABLE_ROWS; i++)
        begin
            r = $random(seed);
            stim_table[i].data = r[31:16];
            stim_table[i].hold = 1'b1;
            if (i < OVER_ROWS)
                stim_table[i].lane = lane_fabric_pkg::lane_id_t'(`LANE_COUNT - 1);
            else if (i < OVER_ROWS + ROT_ROWS)
                stim_table[i].lane = lane_fabric_pkg::lane_id_t'((i - OVER_ROWS) % `LANE_COUNT);
            else
            begin
                stim_table[i].lane = lane_fabric_pkg::lane_id_t'(r[7:0] % `LANE_COUNT);
                stim_table[i].hold = (r[10:8] < 3'd4);  // held about half the time
            end
        end
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial
    begin
        seed       = 50282;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_word    = '0;
        hold       = 1'b0;
        rr_model   = '0;
        pend_valid = 1'b0;
        pend_word  = '0;
        drop_count = 0;
        out_count  = 0;
        for (int i = 0; i < `LANE_COUNT; i++)
        begin
            occ[i]        = 0;
            wrote_last[i] = 1'b0;
        end
        build_table();
        repeat (3) @(posedge rd_clk);
        @(negedge rd_clk);
        reset = 1'b0;

        repeat (10) run_cycle(1'b0, '0, '0, 1'b0);  // quiet after reset

        // last lane held until it overflows
        drop_count = 0;
        apply_rows(0, OVER_ROWS - 1);
        if (drop_count != 2)
            abort_run("held lane did not drop exactly the two extra words");
        out_count = 0;
        drain_all();
        if (out_count != `LANE_DEPTH)
            abort_run("held lane did not return exactly one full buffer of words");

        // all lanes loaded under hold, then read in rotation
        apply_rows(OVER_ROWS, OVER_ROWS + ROT_ROWS - 1);
        drain_all();

        apply_rows(OVER_ROWS + ROT_ROWS, TABLE_ROWS - 1);
        drain_all();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- lane_fabric.f
+incdir+hdl
hdl/lane_fabric_pkg.sv
hdl/lane_fifo.sv
hdl/lane_dispatch.sv
hdl/lane_drain.sv
hdl/lane_fabric.sv
tb/lane_fabric_clkgen.sv
tb/lane_fabric_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the lane fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=lane_fabric_tb
BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP" -f lane_fabric.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "TESTBENCH PASSED" "$LOG_FILE"; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi
